//--- Bender.yml
package:
  name: reflect

sources:
  - design/rt_types_pkg.sv
  - design/rt_bus_pkg.sv
  - design/delay_pipe.sv
  - design/wb_arbiter.sv
  - design/material_store.sv
  - design/material_fetch.sv
  - design/ray_reflector.sv
  - design/reflect_top.sv
  - target: test
    files:
      - verif/reflect_checker.sv
      - verif/reflect_tb.sv

//--- design/delay_pipe.sv
module delay_pipe #(
  parameter type T = logic,
  parameter int DEPTH = 1
) (
  input  logic clk,
  input  logic rst_n,
  input  logic en,
  input  T     d,
  output T     q
);

  T stages [DEPTH];

  // Whole line shifts together, holds when en is low
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stages[i] <= '0;
      end
    end else if (en) begin
      stages[0] <= d;
      for (int i = 1; i < DEPTH; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  assign q = stages[DEPTH-1];

endmodule

//--- design/material_fetch.sv
module material_fetch (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    hit_valid,
  output logic                    hit_ready,
  input  rt_types_pkg::hit_t      hit,
  output rt_bus_pkg::wb_req_t     wb_req,
  input  rt_bus_pkg::wb_rsp_t     wb_rsp,
  output logic                    fetched_valid,
  input  logic                    fetched_ready,
  output rt_types_pkg::hit_t      fetched_hit,
  output rt_types_pkg::material_t fetched_mat
);

  import rt_types_pkg::*;
  import rt_bus_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_PRESENT
  } state_t;

  state_t     state;
  logic [1:0] word_idx;
  hit_t       hit_q;
  material_t  mat_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      word_idx <= 2'd0;
    end else begin
      case (state)
        S_IDLE: begin
          if (hit_valid) begin
            state    <= S_READ;
            word_idx <= 2'd0;
          end
        end
        S_READ: begin
          if (wb_rsp.ack) begin
            word_idx <= word_idx + 2'd1;
            if (word_idx == WORD_SURFACE) begin
              state <= S_PRESENT;
            end
          end
        end
        default: begin
          if (fetched_ready) begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

  // Latch hit and unpack material words as they return
  always_ff @(posedge clk) begin
    if (state == S_IDLE && hit_valid) begin
      hit_q <= hit;
    end
    if (state == S_READ && wb_rsp.ack) begin
      case (word_idx)
        WORD_COLOR: mat_q.color <= wb_rsp.dat[23:0];
        WORD_EMIT:  mat_q.emit_color <= wb_rsp.dat[23:0];
        WORD_SPEC:  mat_q.spec_color <= wb_rsp.dat[23:0];
        default: begin
          mat_q.smoothness    <= wb_rsp.dat[15:8];
          mat_q.specular_prob <= wb_rsp.dat[7:0];
        end
      endcase
    end
  end

  // cyc stays up across all four reads
  assign wb_req.cyc = state == S_READ;
  assign wb_req.stb = state == S_READ;
  assign wb_req.we  = 1'b0;
  assign wb_req.adr = mat_word_adr(hit_q.mat_id, word_idx);
  assign wb_req.dat = '0;

  assign hit_ready     = state == S_IDLE;
  assign fetched_valid = state == S_PRESENT;
  assign fetched_hit   = hit_q;
  assign fetched_mat   = mat_q;

endmodule

//--- design/material_store.sv
module material_store (
  input  logic                clk,
  input  logic                rst_n,
  input  rt_bus_pkg::wb_req_t wb_req,
  output rt_bus_pkg::wb_rsp_t wb_rsp
);

  import rt_bus_pkg::*;

  localparam int DEPTH = MAT_COUNT * MAT_WORDS;
  localparam int AW = $clog2(DEPTH);

  logic [31:0] mem [DEPTH];
  logic [31:0] rdata;
  logic        ack;
  logic        access;
  logic        in_range;

  // New access only while no ack is pending
  assign access   = wb_req.cyc && wb_req.stb && !ack;
  assign in_range = wb_req.adr < 8'(DEPTH);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack <= 1'b0;
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else begin
      ack <= access;
      if (access && wb_req.we && in_range) begin
        mem[wb_req.adr[AW-1:0]] <= wb_req.dat;
      end
    end
  end

  // Out of range reads return zero
  always_ff @(posedge clk) begin
    if (access && !wb_req.we) begin
      rdata <= in_range ? mem[wb_req.adr[AW-1:0]] : '0;
    end
  end

  assign wb_rsp.ack = ack;
  assign wb_rsp.dat = rdata;

endmodule

//--- design/ray_reflector.sv
module ray_reflector (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  rt_types_pkg::hit_t      in_hit,
  input  rt_types_pkg::material_t in_mat,
  output logic                    out_valid,
  input  logic                    out_ready,
  output rt_types_pkg::bounce_t   bounce
);

  import rt_types_pkg::*;

  localparam int LERP_SH = $clog2(LERP_ONE);

  typedef struct packed {
    color_t ray_color;
    color_t income_light;
    color_t base_color;
    color_t spec_color;
  } color_set_t;

  function automatic fx16 reflect_comp(input fx16 d, input fx16 dot, input fx16 n);
    logic signed [32:0] twice;
    logic signed [32:0] diff;
    twice = dot * n;
    twice = twice <<< 1;
    diff = d - (twice >>> FX_FRAC);
    return diff[15:0];
  endfunction

  function automatic fx16 lerp_comp(input fx16 a, input fx16 b, input logic [7:0] t);
    int acc;
    acc = int'(a) * (LERP_ONE - int'(t)) + int'(b) * int'(t);
    return fx16'(acc >>> LERP_SH);
  endfunction

  function automatic chan_t lerp_chan(input chan_t a, input chan_t b, input logic [7:0] t);
    int acc;
    acc = int'(a) * (LERP_ONE - int'(t)) + int'(b) * int'(t);
    return chan_t'(acc >>> LERP_SH);
  endfunction

  function automatic chan_t mul_chan(input chan_t a, input chan_t b);
    logic [15:0] prod;
    prod = a * b;
    return prod[15:8];
  endfunction

  function automatic chan_t sat_add(input chan_t a, input chan_t b);
    logic [8:0] sum;
    sum = a + b;
    return sum[8] ? 8'hff : sum[7:0];
  endfunction

  logic        adv;
  logic        accept;
  logic [15:0] lfsr;
  logic [15:0] lfsr_next;
  logic [7:0]  rnd;

  logic        s1_valid;
  vec3_t       s1_dir;
  vec3_t       s1_normal;
  fx16         s1_dot;
  logic [7:0]  s1_spec_amt;
  color_t      s1_emit;
  logic signed [33:0] dot_full;

  vec3_t       origin_q;
  color_set_t  colors_q;
  vec3_t       spec_dir;
  color_t      mat_color;
  vec3_t       s2_dir;
  color_t      s2_color;
  color_t      s2_light;

  // Both stages advance together, bubbles included
  assign adv      = !out_valid || out_ready;
  assign in_ready = adv;
  assign accept   = in_valid && adv;

  assign lfsr_next = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? PRNG_TAPS : 16'h0000);
  assign rnd       = lfsr_next[7:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lfsr      <= PRNG_SEED;
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (accept) begin
        lfsr <= lfsr_next;
      end
      if (adv) begin
        s1_valid  <= in_valid;
        out_valid <= s1_valid;
      end
    end
  end

  assign dot_full = in_hit.ray_dir.x * in_hit.hit_normal.x
                  + in_hit.ray_dir.y * in_hit.hit_normal.y
                  + in_hit.ray_dir.z * in_hit.hit_normal.z;

  // Stage 1: specular choice, dot product, emission
  always_ff @(posedge clk) begin
    if (adv) begin
      s1_dir      <= in_hit.ray_dir;
      s1_normal   <= in_hit.hit_normal;
      s1_dot      <= fx16'(dot_full >>> FX_FRAC);
      s1_spec_amt <= (rnd < in_mat.specular_prob) ? in_mat.smoothness : 8'd0;
      s1_emit.r   <= mul_chan(in_hit.ray_color.r, in_mat.emit_color.r);
      s1_emit.g   <= mul_chan(in_hit.ray_color.g, in_mat.emit_color.g);
      s1_emit.b   <= mul_chan(in_hit.ray_color.b, in_mat.emit_color.b);
    end
  end

  delay_pipe #(.T(vec3_t), .DEPTH(2)) origin_pipe (
    .clk  (clk),
    .rst_n(rst_n),
    .en   (adv),
    .d    (in_hit.hit_pos),
    .q    (origin_q)
  );

  delay_pipe #(.T(color_set_t), .DEPTH(1)) color_pipe (
    .clk  (clk),
    .rst_n(rst_n),
    .en   (adv),
    .d    ('{in_hit.ray_color, in_hit.income_light, in_mat.color, in_mat.spec_color}),
    .q    (colors_q)
  );

  // Mirror direction and lerped surface color
  always_comb begin
    spec_dir.x  = reflect_comp(s1_dir.x, s1_dot, s1_normal.x);
    spec_dir.y  = reflect_comp(s1_dir.y, s1_dot, s1_normal.y);
    spec_dir.z  = reflect_comp(s1_dir.z, s1_dot, s1_normal.z);
    mat_color.r = lerp_chan(colors_q.base_color.r, colors_q.spec_color.r, s1_spec_amt);
    mat_color.g = lerp_chan(colors_q.base_color.g, colors_q.spec_color.g, s1_spec_amt);
    mat_color.b = lerp_chan(colors_q.base_color.b, colors_q.spec_color.b, s1_spec_amt);
  end

  // Stage 2: diffuse to specular lerp, color filter, light sum
  always_ff @(posedge clk) begin
    if (adv) begin
      s2_dir.x   <= lerp_comp(s1_normal.x, spec_dir.x, s1_spec_amt);
      s2_dir.y   <= lerp_comp(s1_normal.y, spec_dir.y, s1_spec_amt);
      s2_dir.z   <= lerp_comp(s1_normal.z, spec_dir.z, s1_spec_amt);
      s2_color.r <= mul_chan(colors_q.ray_color.r, mat_color.r);
      s2_color.g <= mul_chan(colors_q.ray_color.g, mat_color.g);
      s2_color.b <= mul_chan(colors_q.ray_color.b, mat_color.b);
      s2_light.r <= sat_add(colors_q.income_light.r, s1_emit.r);
      s2_light.g <= sat_add(colors_q.income_light.g, s1_emit.g);
      s2_light.b <= sat_add(colors_q.income_light.b, s1_emit.b);
    end
  end

  assign bounce = '{new_dir: s2_dir, new_origin: origin_q,
                    new_color: s2_color, new_income_light: s2_light};

endmodule

//--- design/reflect_top.sv
module reflect_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  hit_valid,
  output logic                  hit_ready,
  input  rt_types_pkg::hit_t    hit,
  output logic                  out_valid,
  input  logic                  out_ready,
  output rt_types_pkg::bounce_t bounce,
  input  rt_bus_pkg::wb_req_t   host_req,
  output rt_bus_pkg::wb_rsp_t   host_rsp
);

  import rt_types_pkg::*;
  import rt_bus_pkg::*;

  logic      fetched_valid;
  logic      fetched_ready;
  hit_t      fetched_hit;
  material_t fetched_mat;

  wb_req_t   fetch_req;
  wb_rsp_t   fetch_rsp;
  wb_req_t   store_req;
  wb_rsp_t   store_rsp;

  material_fetch u_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .hit_valid    (hit_valid),
    .hit_ready    (hit_ready),
    .hit          (hit),
    .wb_req       (fetch_req),
    .wb_rsp       (fetch_rsp),
    .fetched_valid(fetched_valid),
    .fetched_ready(fetched_ready),
    .fetched_hit  (fetched_hit),
    .fetched_mat  (fetched_mat)
  );

  ray_reflector u_reflector (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (fetched_valid),
    .in_ready (fetched_ready),
    .in_hit   (fetched_hit),
    .in_mat   (fetched_mat),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .bounce   (bounce)
  );

  // Fetcher is m0, host port is m1
  wb_arbiter u_arbiter (
    .clk   (clk),
    .rst_n (rst_n),
    .m0_req(fetch_req),
    .m0_rsp(fetch_rsp),
    .m1_req(host_req),
    .m1_rsp(host_rsp),
    .s_req (store_req),
    .s_rsp (store_rsp)
  );

  material_store u_store (
    .clk   (clk),
    .rst_n (rst_n),
    .wb_req(store_req),
    .wb_rsp(store_rsp)
  );

endmodule

//--- design/rt_bus_pkg.sv
package rt_bus_pkg;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [7:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  localparam int MAT_COUNT = 16;
  localparam int MAT_WORDS = 4;

  // Word index inside one material record
  localparam logic [1:0] WORD_COLOR = 2'd0;
  localparam logic [1:0] WORD_EMIT = 2'd1;
  localparam logic [1:0] WORD_SPEC = 2'd2;
  localparam logic [1:0] WORD_SURFACE = 2'd3;

  function automatic logic [7:0] mat_word_adr(input logic [3:0] mat_id, input logic [1:0] word);
    return 8'(mat_id * MAT_WORDS + word);
  endfunction

endpackage

//--- design/rt_types_pkg.sv
package rt_types_pkg;

  // Signed Q2.14 scalar
  typedef logic signed [15:0] fx16;

  typedef struct packed {
    fx16 x;
    fx16 y;
    fx16 z;
  } vec3_t;

  // Channel value is a fraction of 256
  typedef logic [7:0] chan_t;

  typedef struct packed {
    chan_t r;
    chan_t g;
    chan_t b;
  } color_t;

  typedef struct packed {
    color_t     color;
    color_t     emit_color;
    color_t     spec_color;
    logic [7:0] smoothness;
    logic [7:0] specular_prob;
  } material_t;

  typedef struct packed {
    vec3_t      ray_dir;
    vec3_t      hit_pos;
    vec3_t      hit_normal;
    color_t     ray_color;
    color_t     income_light;
    logic [3:0] mat_id;
  } hit_t;

  typedef struct packed {
    vec3_t  new_dir;
    vec3_t  new_origin;
    color_t new_color;
    color_t new_income_light;
  } bounce_t;

  localparam int FX_FRAC = 14;
  localparam int LERP_ONE = 256;

  // Galois LFSR setup
  localparam logic [15:0] PRNG_SEED = 16'hace1;
  localparam logic [15:0] PRNG_TAPS = 16'hb400;

endpackage

//--- design/wb_arbiter.sv
module wb_arbiter (
  input  logic                clk,
  input  logic                rst_n,
  input  rt_bus_pkg::wb_req_t m0_req,
  output rt_bus_pkg::wb_rsp_t m0_rsp,
  input  rt_bus_pkg::wb_req_t m1_req,
  output rt_bus_pkg::wb_rsp_t m1_rsp,
  output rt_bus_pkg::wb_req_t s_req,
  input  rt_bus_pkg::wb_rsp_t s_rsp
);

  // One-hot owner, zero when the bus is idle
  logic [1:0] owner;
  logic [1:0] grant;
  // High when m1 was served last
  logic       last_served;

  always_comb begin
    if (owner[0] && m0_req.cyc) begin
      grant = 2'b01;
    end else if (owner[1] && m1_req.cyc) begin
      grant = 2'b10;
    end else if (m0_req.cyc && m1_req.cyc) begin
      grant = last_served ? 2'b01 : 2'b10;
    end else begin
      grant = {m1_req.cyc, m0_req.cyc};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      owner       <= 2'b00;
      last_served <= 1'b1;
    end else begin
      owner <= grant;
      if (|grant) begin
        last_served <= grant[1];
      end
    end
  end

  assign s_req = grant[1] ? m1_req : (grant[0] ? m0_req : '0);

  // Responses go to the granted master only
  assign m0_rsp.ack = s_rsp.ack && grant[0];
  assign m0_rsp.dat = grant[0] ? s_rsp.dat : '0;
  assign m1_rsp.ack = s_rsp.ack && grant[1];
  assign m1_rsp.dat = grant[1] ? s_rsp.dat : '0;

endmodule

//--- list.f
design/rt_types_pkg.sv
design/rt_bus_pkg.sv
design/delay_pipe.sv
design/wb_arbiter.sv
design/material_store.sv
design/material_fetch.sv
design/ray_reflector.sv
design/reflect_top.sv
verif/reflect_checker.sv
verif/reflect_tb.sv

//--- verif/reflect_checker.sv
module reflect_checker (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  out_valid,
  input logic                  out_ready,
  input rt_types_pkg::bounce_t bounce,
  input logic                  hit_ready,
  input rt_bus_pkg::wb_req_t   wb_req,
  input rt_bus_pkg::wb_rsp_t   wb_rsp
);

  int failures = 0;

  // Output record frozen while the sink stalls
  stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(bounce))
    else begin
      $error("bounce changed while out_ready was low");
      failures++;
    end

  // Store bus, ack only answers a live request
  ack_with_req: assert property (@(posedge clk) disable iff (!rst_n)
    wb_rsp.ack |-> wb_req.cyc && wb_req.stb)
    else begin
      $error("store ack without cyc and stb");
      failures++;
    end

  ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_rsp.ack |=> !wb_rsp.ack)
    else begin
      $error("store ack held longer than one cycle");
      failures++;
    end

  reset_values: assert property (@(posedge clk) !rst_n |=> !out_valid && hit_ready)
    else begin
      $error("out_valid or hit_ready wrong after reset");
      failures++;
    end

endmodule

//--- verif/reflect_tb.sv
module reflect_tb;

  import rt_types_pkg::*;
  import rt_bus_pkg::*;

  localparam int WAIT_LIMIT = 300;

  typedef struct {
    string     name;
    material_t mat;
  } mat_entry_t;

  typedef struct {
    string name;
    hit_t  hit;
  } hit_entry_t;

  typedef struct {
    string   name;
    bounce_t b;
  } expect_t;

  logic        clk;
  logic        rst_n;
  logic        hit_valid;
  logic        hit_ready;
  hit_t        hit;
  logic        out_valid;
  logic        out_ready;
  bounce_t     bounce;
  wb_req_t     host_req;
  wb_rsp_t     host_rsp;

  mat_entry_t  mat_tab [8];
  hit_entry_t  hit_tab [10];
  material_t   mats [MAT_COUNT];
  expect_t     expected [$];
  logic [15:0] lfsr_model;

  always #5 clk = ~clk;

  reflect_top dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .hit_valid(hit_valid),
    .hit_ready(hit_ready),
    .hit      (hit),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .bounce   (bounce),
    .host_req (host_req),
    .host_rsp (host_rsp)
  );

  bind reflect_top reflect_checker u_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .bounce   (bounce),
    .hit_ready(hit_ready),
    .wb_req   (store_req),
    .wb_rsp   (store_rsp)
  );

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    assert (dut0.u_checker.failures == 0) else begin
      stop_run("bound protocol assertions reported errors");
    end
  end

  task automatic check_equal(input string name, input logic [143:0] exp,
                             input logic [143:0] got);
    assert (exp === got) else begin
      stop_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, got));
    end
  endtask

  function automatic logic [31:0] material_word(input int id, input int w);
    material_t m;
    m = mats[id];
    case (w)
      0: return {8'h00, m.color};
      1: return {8'h00, m.emit_color};
      2: return {8'h00, m.spec_color};
      default: return {16'h0000, m.smoothness, m.specular_prob};
    endcase
  endfunction

  // Color filter through the blended surface color
  function automatic chan_t filter_chan(input int ray, input int base, input int spec,
                                        input int s);
    int surface;
    surface = (base * (LERP_ONE - s) + spec * s) / LERP_ONE;
    return chan_t'((ray * surface) / 256);
  endfunction

  function automatic chan_t light_chan(input int income, input int ray, input int emit);
    int sum;
    sum = income + (ray * emit) / 256;
    return (sum > 255) ? 8'hff : chan_t'(sum);
  endfunction

  task automatic predict_bounce(input hit_t h, output bounce_t b);
    material_t m;
    logic      feedback;
    int        s;
    longint    dv [3];
    longint    nv [3];
    longint    dot;
    longint    mirror;
    fx16       trunc;
    fx16       dir [3];
    m = mats[h.mat_id];
    // Galois step whose new low byte is this hit's draw
    feedback = lfsr_model[0];
    lfsr_model = lfsr_model >> 1;
    if (feedback) begin
      lfsr_model = lfsr_model ^ PRNG_TAPS;
    end
    s = (lfsr_model[7:0] < m.specular_prob) ? int'(m.smoothness) : 0;
    dv = '{$signed(h.ray_dir.x), $signed(h.ray_dir.y), $signed(h.ray_dir.z)};
    nv = '{$signed(h.hit_normal.x), $signed(h.hit_normal.y), $signed(h.hit_normal.z)};
    dot = (dv[0] * nv[0] + dv[1] * nv[1] + dv[2] * nv[2]) >>> FX_FRAC;
    trunc = fx16'(dot);
    dot = trunc;
    for (int k = 0; k < 3; k++) begin
      mirror = dv[k] - ((2 * dot * nv[k]) >>> FX_FRAC);
      trunc = fx16'(mirror);
      mirror = trunc;
      // 8 fraction bits in the blend weight
      dir[k] = fx16'((nv[k] * (LERP_ONE - s) + mirror * s) >>> 8);
    end
    b.new_dir = '{x: dir[0], y: dir[1], z: dir[2]};
    b.new_origin = h.hit_pos;
    b.new_color.r = filter_chan(h.ray_color.r, m.color.r, m.spec_color.r, s);
    b.new_color.g = filter_chan(h.ray_color.g, m.color.g, m.spec_color.g, s);
    b.new_color.b = filter_chan(h.ray_color.b, m.color.b, m.spec_color.b, s);
    b.new_income_light.r = light_chan(h.income_light.r, h.ray_color.r, m.emit_color.r);
    b.new_income_light.g = light_chan(h.income_light.g, h.ray_color.g, m.emit_color.g);
    b.new_income_light.b = light_chan(h.income_light.b, h.ray_color.b, m.emit_color.b);
  endtask

  task automatic fill_tables();
    // color, emit, spec, smoothness, specular_prob
    mat_tab[0] = '{"diffuse", {24'hc08040, 24'h000000, 24'hffffff, 8'd200, 8'd0}};
    mat_tab[1] = '{"mirror", {24'h204060, 24'h000000, 24'hf0f0f0, 8'd255, 8'd255}};
    mat_tab[2] = '{"glossy_mix", {24'h80a0c0, 24'h000000, 24'hffe0c0, 8'd180, 8'd128}};
    mat_tab[3] = '{"emitter", {24'h404040, 24'hffffff, 24'h808080, 8'd100, 8'd64}};
    mat_tab[4] = '{"warm_emit", {24'hff8000, 24'h80ff40, 24'hffffff, 8'd220, 8'd200}};
    mat_tab[5] = '{"dark_mix", {24'h101010, 24'h202020, 24'hc0c0c0, 8'd128, 8'd30}};
    mat_tab[6] = '{"chrome", {24'hd0d0d0, 24'h000000, 24'hffffff, 8'd240, 8'd240}};
    mat_tab[7] = '{"rough_glass", {24'h60c0ff, 24'h102030, 24'h40ff80, 8'd60, 8'd160}};
    // dir, pos, normal, ray_color, income_light, mat_id
    hit_tab[0] = '{"diffuse_floor", {48'h2d41_d2bf_0000, 48'h1000_0000_2000,
                   48'h0000_4000_0000, 24'hffffff, 24'h000000, 4'd0}};
    hit_tab[1] = '{"mirror_wall", {48'h4000_0000_0000, 48'h3000_1000_0000,
                   48'hc000_0000_0000, 24'he0e0e0, 24'h102030, 4'd1}};
    hit_tab[2] = '{"mirror_slant", {48'h2d41_d2bf_0000, 48'hf000_0800_1000,
                   48'h0000_4000_0000, 24'hffffff, 24'h000000, 4'd1}};
    hit_tab[3] = '{"glossy_a", {48'h2000_d2bf_2000, 48'h0400_e000_0c00,
                   48'h0000_4000_0000, 24'hc0c0c0, 24'h080808, 4'd2}};
    hit_tab[4] = '{"emit_saturate", {48'h0000_c000_0000, 48'h2000_2000_2000,
                   48'h0000_4000_0000, 24'hffffff, 24'hf0f0f0, 4'd3}};
    hit_tab[5] = '{"warm_glow", {48'he000_e000_2d41, 48'hd000_1800_3800,
                   48'h0000_0000_c000, 24'h80c0ff, 24'h404040, 4'd4}};
    hit_tab[6] = '{"dark_patch", {48'h2d41_0000_d2bf, 48'h0100_0200_0300,
                   48'h0000_0000_4000, 24'hffffff, 24'h000000, 4'd5}};
    hit_tab[7] = '{"chrome_edge", {48'hd2bf_d2bf_0000, 48'h1234_edcc_0040,
                   48'h2d41_2d41_0000, 24'ha0b0c0, 24'h203040, 4'd6}};
    hit_tab[8] = '{"glass_pane", {48'h0000_2d41_d2bf, 48'hc800_3800_0000,
                   48'h0000_0000_4000, 24'hffffff, 24'hc0c0c0, 4'd7}};
    hit_tab[9] = '{"upper_material", {48'h2000_e000_2d41, 48'h0a00_f600_1400,
                   48'h0000_c000_0000, 24'hffffff, 24'h7f7f7f, 4'd12}};
    // Upper eight ids reuse the table with an id dependent base color
    for (int i = 0; i < MAT_COUNT; i++) begin
      mats[i] = mat_tab[i % 8].mat;
      if (i >= 8) begin
        mats[i].color = mats[i].color ^ {3{8'(i * 37)}};
      end
    end
  endtask

  // Single host cycle held until ack has been sampled
  task automatic host_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
    int cycles;
    host_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    cycles = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        stop_run($sformatf("timeout waiting for host ack at address %0d", adr));
      end
    end while (!host_rsp.ack);
    rdat = host_rsp.dat;
    @(posedge clk);
    #1;
    host_req = '0;
  endtask

  task automatic host_reads(input int count);
    logic [31:0] rd;
    logic [7:0]  adr;
    for (int k = 0; k < count; k++) begin
      adr = 8'((k * 23 + 5) % (MAT_COUNT * MAT_WORDS));
      host_access(1'b0, adr, 32'h0, rd);
      check_equal($sformatf("host read %0d", adr), 144'(material_word(adr / 4, adr % 4)),
                  144'(rd));
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_hit(input hit_entry_t e, input int pass);
    int      cycles;
    expect_t x;
    hit = e.hit;
    hit_valid = 1'b1;
    cycles = 0;
    while (!hit_ready) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        stop_run($sformatf("timeout waiting for hit_ready on %s", e.name));
      end
    end
    x.name = $sformatf("%s pass %0d", e.name, pass);
    predict_bounce(e.hit, x.b);
    expected.push_back(x);
    @(posedge clk);
    #1;
    hit_valid = 1'b0;
  endtask

  task automatic collect_bounces(input int count, input logic stall);
    int      got;
    int      cycles;
    expect_t x;
    got = 0;
    cycles = 0;
    while (got < count) begin
      out_ready = stall ? ($urandom % 4 != 0) : 1'b1;
      if (out_valid && out_ready) begin
        assert (expected.size() > 0) else begin
          stop_run("bounce arrived with no hit outstanding");
        end
        x = expected.pop_front();
        check_equal(x.name, x.b, bounce);
        got++;
        cycles = 0;
      end
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        stop_run("timeout waiting for out_valid");
      end
    end
    out_ready = 1'b1;
  endtask

  initial begin
    logic [31:0] rd;
    clk = 1'b0;
    rst_n = 1'b0;
    hit_valid = 1'b0;
    hit = '0;
    out_ready = 1'b0;
    host_req = '0;
    void'($urandom(32'h8399_12c7));
    lfsr_model = PRNG_SEED;
    fill_tables();
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    out_ready = 1'b1;

    // Load every material over the host port and read it back
    for (int a = 0; a < MAT_COUNT * MAT_WORDS; a++) begin
      host_access(1'b1, 8'(a), material_word(a / 4, a % 4), rd);
    end
    for (int a = 0; a < MAT_COUNT * MAT_WORDS; a++) begin
      host_access(1'b0, 8'(a), 32'h0, rd);
      check_equal($sformatf("readback word %0d", a), 144'(material_word(a / 4, a % 4)),
                  144'(rd));
    end

    // Back-to-back hits with the sink always ready
    fork
      begin
        for (int i = 0; i < 10; i++) begin
          send_hit(hit_tab[i], 0);
        end
      end
      collect_bounces(10, 1'b0);
    join

    // Random stalls plus host reads sharing the store
    fork
      begin
        for (int i = 0; i < 10; i++) begin
          send_hit(hit_tab[i], 1);
        end
      end
      collect_bounces(10, 1'b1);
      host_reads(12);
    join

    repeat (20) begin
      @(posedge clk);
      #1;
      assert (!out_valid) else begin
        stop_run("extra bounce after all hits were answered");
      end
    end

    if (dut0.u_checker.failures == 0) begin
      $display("test passed");
      $finish;
    end else begin
      stop_run("bound protocol assertions reported errors");
    end
  end

endmodule
